// File: design/nandByteSerializer.sv
`default_nettype none

module nandByteSerializer (
    input  logic                                    iSystemClock,
    input  logic                                    rstN,
    input  logic                                    go,
    input  logic [nandDataOutPkg::countWidth-1:0]   byteCount,
    input  logic [nandDataOutPkg::wordWidth-1:0]    headWord,
    input  logic                                    empty,
    output logic                                    pop,
    output logic                                    done,
    output logic                                    writeEnableN,
    output logic [nandDataOutPkg::byteWidth-1:0]    dq
);
    import nandDataOutPkg::*;

    serState_t state;
    slotCount_t slotTimer;
    logic [countWidth-1:0] bytesStarted;
    logic lowByte;                          // next byte is the low half
    logic lastSlot;
    logic slotEnd;
    logic isLastByte;
    logic canStart;

    assign slotEnd = (state == serSlot) && (slotTimer == slotCount_t'(slotCycles - 1));
    assign isLastByte = ((bytesStarted + 1'b1) == byteCount);

    always_comb begin
        canStart = 1'b0;
        if (!empty) begin
            canStart = ((state == serIdle) && go) ||
                       (state == serWait) ||
                       (slotEnd && !lastSlot);
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            state <= serIdle;
            slotTimer <= '0;
            bytesStarted <= '0;
            lowByte <= 1'b0;
            lastSlot <= 1'b0;
            pop <= 1'b0;
            done <= 1'b0;
            writeEnableN <= 1'b1;
        end else begin
            pop <= 1'b0;
            done <= 1'b0;
            if (canStart) begin
                state <= serSlot;
                slotTimer <= '0;
                writeEnableN <= 1'b0;
                lowByte <= ~lowByte;
                lastSlot <= isLastByte;
                bytesStarted <= bytesStarted + 1'b1;
                // word is used up once its final byte is in dq
                pop <= lowByte || isLastByte;
            end else if (slotEnd) begin
                writeEnableN <= 1'b1;
                if (lastSlot) begin
                    state <= serIdle;
                    done <= 1'b1;
                    bytesStarted <= '0;
                    lowByte <= 1'b0;
                end else begin
                    state <= serWait;   // host fell behind
                end
            end else if ((state == serIdle) && go) begin
                state <= serWait;
            end else if (state == serSlot) begin
                slotTimer <= slotTimer + 1'b1;
                writeEnableN <= (slotTimer >= slotCount_t'(weLowCycles - 1));
            end
        end
    end

    // byte held for the whole slot
    always_ff @(posedge iSystemClock) begin
        if (canStart) begin
            dq <= lowByte ? headWord[byteWidth-1:0] : headWord[wordWidth-1:byteWidth];
        end
    end

    assert property (@(posedge iSystemClock) disable iff (!rstN)
        !writeEnableN |-> (state == serSlot));

endmodule

`default_nettype wire

// File: design/nandDataOut.sv
`default_nettype none

module nandDataOut (
    input  logic                                    iSystemClock,
    input  logic                                    rstN,
    input  logic                                    start,
    input  logic [nandDataOutPkg::numWays-1:0]      targetWay,
    input  logic [nandDataOutPkg::countWidth-1:0]   numOfData,
    input  logic [nandDataOutPkg::wordWidth-1:0]    writeData,
    input  logic                                    writeValid,
    output logic                                    ready,
    output logic                                    lastStep,
    output logic                                    writeReady,
    output logic [nandDataOutPkg::numWays-1:0]      chipEnableN,
    output logic                                    writeEnableN,
    output logic [nandDataOutPkg::byteWidth-1:0]    dq
);
    import nandDataOutPkg::*;

    logic go;
    logic done;
    logic [countWidth-1:0] byteCount;
    logic bufFull;
    logic bufEmpty;
    logic bufPop;
    logic [wordWidth-1:0] headWord;

    nandDataOutCtrl ctrl (
        .iSystemClock (iSystemClock),
        .rstN         (rstN),
        .start        (start),
        .targetWay    (targetWay),
        .numOfData    (numOfData),
        .writeValid   (writeValid),
        .full         (bufFull),
        .done         (done),
        .ready        (ready),
        .lastStep     (lastStep),
        .writeReady   (writeReady),
        .chipEnableN  (chipEnableN),
        .go           (go),
        .byteCount    (byteCount)
    );

    // host word lands at the end of the writeReady cycle
    nandWordBuffer wordBuffer (
        .iSystemClock (iSystemClock),
        .rstN         (rstN),
        .push         (writeReady),
        .pushWord     (writeData),
        .pop          (bufPop),
        .headWord     (headWord),
        .empty        (bufEmpty),
        .full         (bufFull)
    );

    nandByteSerializer serializer (
        .iSystemClock (iSystemClock),
        .rstN         (rstN),
        .go           (go),
        .byteCount    (byteCount),
        .headWord     (headWord),
        .empty        (bufEmpty),
        .pop          (bufPop),
        .done         (done),
        .writeEnableN (writeEnableN),
        .dq           (dq)
    );

endmodule

`default_nettype wire

// File: design/nandDataOutCtrl.sv
`default_nettype none

module nandDataOutCtrl (
    input  logic                                     iSystemClock,
    input  logic                                     rstN,
    input  logic                                     start,
    input  logic [nandDataOutPkg::numWays-1:0]       targetWay,
    input  logic [nandDataOutPkg::countWidth-1:0]    numOfData,
    input  logic                                     writeValid,
    input  logic                                     full,
    input  logic                                     done,
    output logic                                     ready,
    output logic                                     lastStep,
    output logic                                     writeReady,
    output logic [nandDataOutPkg::numWays-1:0]       chipEnableN,
    output logic                                     go,
    output logic [nandDataOutPkg::countWidth-1:0]    byteCount
);
    import nandDataOutPkg::*;

    ctrlState_t state;
    slotCount_t setupTimer;
    logic [numWays-1:0] wayMask;
    logic [countWidth-1:0] wordsOwed;
    logic accept;
    logic fetchOk;
    logic setupDone;

    assign accept = start && ready && (state == ctrlIdle);
    assign setupDone = (setupTimer == slotCount_t'(setupCycles - 1));

    // one word per strobe, never back to back
    assign fetchOk = (state == ctrlTransfer) &&
                     (wordsOwed != '0) &&
                     !full &&
                     writeValid &&
                     !writeReady;

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            state <= ctrlIdle;
            ready <= 1'b0;
            lastStep <= 1'b0;
            writeReady <= 1'b0;
            chipEnableN <= '1;
            go <= 1'b0;
            setupTimer <= '0;
            wordsOwed <= '0;
        end else begin
            go <= 1'b0;
            lastStep <= 1'b0;
            writeReady <= fetchOk;
            if (writeReady) begin
                wordsOwed <= wordsOwed - 1'b1;   // word pushed this cycle
            end
            case (state)
                ctrlIdle: begin
                    if (accept) begin
                        state <= ctrlLatch;
                        ready <= 1'b0;
                        // bytes rounded up to words
                        wordsOwed <= (numOfData >> 1) + numOfData[0];
                    end else begin
                        ready <= 1'b1;
                    end
                end
                ctrlLatch: begin
                    chipEnableN <= ~wayMask;
                    setupTimer <= '0;
                    state <= ctrlSetup;
                end
                ctrlSetup: begin
                    if (setupDone) begin
                        go <= 1'b1;
                        state <= ctrlTransfer;
                    end else begin
                        setupTimer <= setupTimer + 1'b1;
                    end
                end
                ctrlTransfer: begin
                    if (done) begin
                        lastStep <= 1'b1;
                        chipEnableN <= '1;   // deselect with lastStep
                        state <= ctrlFinish;
                    end
                end
                ctrlFinish: begin
                    ready <= 1'b1;
                    state <= ctrlIdle;
                end
                default: begin
                    state <= ctrlIdle;
                end
            endcase
        end
    end

    // command payload
    always_ff @(posedge iSystemClock) begin
        if (accept) begin
            wayMask <= targetWay;
            byteCount <= numOfData;
        end
    end

    // serializer finishes only after every owed word was taken
    assert property (@(posedge iSystemClock) disable iff (!rstN)
        done |-> (wordsOwed == '0));

    // a zero count would hang the serializer
    assert property (@(posedge iSystemClock) disable iff (!rstN)
        (start && ready) |-> (numOfData != '0));

endmodule

`default_nettype wire

// File: design/nandDataOutPkg.sv
`default_nettype none

package nandDataOutPkg;

    localparam int numWays = 4;
    localparam int wordWidth = 16;
    localparam int byteWidth = 8;
    localparam int countWidth = 16;          // byte count width

    localparam int slotCycles = 10;          // one byte on the bus
    localparam int weLowCycles = 5;
    localparam int setupCycles = 10;         // chip enable to first data

    typedef logic [3:0] slotCount_t;

    typedef enum logic [2:0] {
        ctrlIdle,
        ctrlLatch,
        ctrlSetup,
        ctrlTransfer,
        ctrlFinish
    } ctrlState_t;

    typedef enum logic [1:0] {
        serIdle,
        serWait,                             // buffer empty, bus idle
        serSlot
    } serState_t;

endpackage

`default_nettype wire

// File: design/nandWordBuffer.sv
`default_nettype none

module nandWordBuffer (
    input  logic                                    iSystemClock,
    input  logic                                    rstN,
    input  logic                                    push,
    input  logic [nandDataOutPkg::wordWidth-1:0]    pushWord,
    input  logic                                    pop,
    output logic [nandDataOutPkg::wordWidth-1:0]    headWord,
    output logic                                    empty,
    output logic                                    full
);
    import nandDataOutPkg::*;

    logic [wordWidth-1:0] mem [2];
    logic wrPtr;
    logic rdPtr;
    logic [1:0] count;                      // 0..2 words held

    assign headWord = mem[rdPtr];
    assign empty = (count == 2'd0);
    assign full = (count == 2'd2);

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push) begin
                wrPtr <= ~wrPtr;
            end
            if (pop) begin
                rdPtr <= ~rdPtr;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (push) begin
            mem[wrPtr] <= pushWord;
        end
    end

    // ctrl gates writeReady on full one cycle early
    assert property (@(posedge iSystemClock) disable iff (!rstN)
        push |-> !full);

    assert property (@(posedge iSystemClock) disable iff (!rstN)
        pop |-> !empty);

endmodule

`default_nettype wire

// File: nandDataOut.f
design/nandDataOutPkg.sv
design/nandDataOutCtrl.sv
design/nandWordBuffer.sv
design/nandByteSerializer.sv
design/nandDataOut.sv
sim/clockGen.sv
sim/nandDataOutTb.sv

// File: run.sh
#!/bin/sh
# Build and run the nandDataOut testbench with Verilator.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f nandDataOut.f --top-module nandDataOutTb \
    -Mdir obj_dir -o nandDataOutSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/nandDataOutSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

exit 0

// File: sim/clockGen.sv
`default_nettype none

module clockGen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int halfPeriod = 4;          // 8 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: sim/nandDataOutTb.sv
`default_nettype none

module nandDataOutTb;
    timeunit 1ns;
    timeprecision 100ps;
    import nandDataOutPkg::*;

    localparam int numCommands = 40;
    localparam int maxDelay = 12;
    localparam int readyTimeout = 100;
    localparam int acceptTimeout = 200;
    localparam int finishTimeout = 200;

    logic iSystemClock;
    logic rstN;
    logic start;
    logic [numWays-1:0] targetWay;
    logic [countWidth-1:0] numOfData;
    logic [wordWidth-1:0] writeData;
    logic writeValid;
    logic ready;
    logic lastStep;
    logic writeReady;
    logic [numWays-1:0] chipEnableN;
    logic writeEnableN;
    logic [byteWidth-1:0] dq;

    int seed = 19;
    int cycle = 0;                          // bumped at every falling clock edge
    logic monitorOn = 1'b0;
    logic active = 1'b0;                    // a command is in flight
    logic ceSeen;
    logic fallSeen;
    logic prevWe = 1'b1;
    int startCycle;
    int ceFallCycle;
    int lastFall;
    int lastRise;
    int writeReadyCount;
    logic [numWays-1:0] cmdMask;
    logic [byteWidth-1:0] heldDq;
    logic [byteWidth-1:0] gotBytes [$];
    logic [wordWidth-1:0] modelWords [$];

    clockGen clock (
        .clk (iSystemClock)
    );

    nandDataOut uut (
        .iSystemClock (iSystemClock),
        .rstN         (rstN),
        .start        (start),
        .targetWay    (targetWay),
        .numOfData    (numOfData),
        .writeData    (writeData),
        .writeValid   (writeValid),
        .ready        (ready),
        .lastStep     (lastStep),
        .writeReady   (writeReady),
        .chipEnableN  (chipEnableN),
        .writeEnableN (writeEnableN),
        .dq           (dq)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkByte(input string name, input logic [byteWidth-1:0] expected,
                             input logic [byteWidth-1:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR at %0t: %s expected %h got %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic checkWays(input string name, input logic [numWays-1:0] expected,
                             input logic [numWays-1:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR at %0t: %s expected %b got %b",
                               $time, name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR at %0t: %s expected %b got %b",
                               $time, name, expected, actual));
        end
    endtask

    task automatic checkCount(input string name, input logic [countWidth-1:0] expected,
                              input logic [countWidth-1:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR at %0t: %s expected %0d got %0d",
                               $time, name, expected, actual));
        end
    endtask

    // high byte of each word first, count may end mid word
    function automatic logic [byteWidth-1:0] expectedByte(input int index);
        logic [wordWidth-1:0] word;
        word = modelWords[index / 2];
        if (index % 2 == 0) begin
            return word[wordWidth-1:byteWidth];
        end
        return word[byteWidth-1:0];
    endfunction

    task automatic checkIdlePins(input logic readyLevel);
        checkFlag("ready", readyLevel, ready);
        checkFlag("lastStep", 1'b0, lastStep);
        checkFlag("writeReady", 1'b0, writeReady);
        checkFlag("writeEnableN", 1'b1, writeEnableN);
        checkWays("chipEnableN", '1, chipEnableN);
    endtask

    task automatic watchCommand();
        if (lastStep) begin
            if (!active) begin
                abortRun("lastStep pulsed while no command was running");
            end else begin
                checkCount("lastStep delay after writeEnableN rise",
                           countWidth'(slotCycles - weLowCycles + 1),
                           countWidth'(cycle - lastRise));
                checkWays("chipEnableN", '1, chipEnableN);
                checkFlag("ready", 1'b0, ready);
                active = 1'b0;
            end
        end else if (active) begin
            if (cycle > startCycle) begin
                checkFlag("ready", 1'b0, ready);
            end
            if (writeReady) begin
                writeReadyCount++;
            end
            if (chipEnableN != '1) begin
                if (!ceSeen) begin
                    ceSeen = 1'b1;
                    ceFallCycle = cycle;
                    checkCount("chipEnableN delay after start", countWidth'(2),
                               countWidth'(cycle - startCycle));
                end
                checkWays("chipEnableN", ~cmdMask, chipEnableN);
            end else if (ceSeen) begin
                abortRun("chip enable was released before lastStep");
            end
        end else begin
            checkFlag("ready", 1'b1, ready);
            checkFlag("writeReady", 1'b0, writeReady);
            checkWays("chipEnableN", '1, chipEnableN);
        end
    endtask

    task automatic watchWriteEnable();
        if (!writeEnableN) begin
            if (chipEnableN == '1) begin
                abortRun("write enable went low while no way was selected");
            end
            if (prevWe) begin                // falling edge
                if (!fallSeen) begin
                    if (!ceSeen || (cycle - ceFallCycle < setupCycles)) begin
                        abortRun("first write enable pulse came before the setup time");
                    end
                end else if (cycle - lastFall < slotCycles) begin
                    abortRun("write enable pulses were closer than one byte slot");
                end
                fallSeen = 1'b1;
                lastFall = cycle;
                heldDq = dq;
            end else begin
                checkByte("dq", heldDq, dq);
            end
        end else if (!prevWe) begin          // rising edge latches the byte
            checkCount("writeEnableN low cycles", countWidth'(weLowCycles),
                       countWidth'(cycle - lastFall));
            checkByte("dq", heldDq, dq);
            gotBytes.push_back(dq);
            lastRise = cycle;
        end
    endtask

    // pins sampled mid cycle
    always @(negedge iSystemClock) begin
        cycle = cycle + 1;
        if (monitorOn) begin
            watchCommand();
            watchWriteEnable();
        end
        prevWe = writeEnableN;
    end

    task automatic applyReset();
        @(posedge iSystemClock);
        repeat (7) begin
            @(negedge iSystemClock);
            checkIdlePins(1'b0);
            @(posedge iSystemClock);
        end
        #1;
        rstN = 1'b1;
        @(negedge iSystemClock);
        checkIdlePins(1'b0);                 // first cycle after release
        @(negedge iSystemClock);
        checkIdlePins(1'b1);
        @(posedge iSystemClock);
        #1;
        monitorOn = 1'b1;
    endtask

    task automatic waitReady();
        int waited;
        waited = 0;
        @(negedge iSystemClock);
        while (!ready) begin
            waited++;
            if (waited > readyTimeout) begin
                abortRun("timeout waiting for ready");
            end
            @(negedge iSystemClock);
        end
    endtask

    task automatic waitLastStep();
        int waited;
        waited = 0;
        @(negedge iSystemClock);
        while (!lastStep) begin
            waited++;
            if (waited > finishTimeout) begin
                abortRun("timeout waiting for lastStep");
            end
            @(negedge iSystemClock);
        end
    endtask

    task automatic sendWord();
        logic [wordWidth-1:0] word;
        int delay;
        int waited;
        word = wordWidth'($random(seed));
        delay = $unsigned($random(seed)) % (maxDelay + 1);
        repeat (delay) begin
            @(posedge iSystemClock);
            #1;
        end
        writeValid = 1'b1;
        writeData = word;
        waited = 0;
        @(negedge iSystemClock);
        while (!writeReady) begin
            waited++;
            if (waited > acceptTimeout) begin
                abortRun("timeout waiting for writeReady");
            end
            @(negedge iSystemClock);
        end
        modelWords.push_back(word);          // pushed at the coming edge
        @(posedge iSystemClock);
        #1;
        writeValid = 1'b0;
        writeData = wordWidth'($random(seed));
    endtask

    task automatic runCommand();
        logic [numWays-1:0] mask;
        logic [countWidth-1:0] count;
        int numWords;
        mask = numWays'(1 + ($unsigned($random(seed)) % ((1 << numWays) - 1)));
        count = countWidth'(1 + ($unsigned($random(seed)) % 9));
        numWords = (int'(count) + 1) / 2;
        waitReady();
        @(posedge iSystemClock);
        #1;
        modelWords.delete();
        gotBytes.delete();
        writeReadyCount = 0;
        ceSeen = 1'b0;
        fallSeen = 1'b0;
        lastRise = 0;
        cmdMask = mask;
        startCycle = cycle + 1;
        active = 1'b1;
        start = 1'b1;
        targetWay = mask;
        numOfData = count;
        @(posedge iSystemClock);
        #1;
        start = 1'b0;
        targetWay = '0;
        numOfData = '0;
        repeat (numWords) begin
            sendWord();
        end
        waitLastStep();
        @(negedge iSystemClock);             // ready rises here
        @(posedge iSystemClock);
        #1;
        checkCount("writeReady pulses", countWidth'(numWords), countWidth'(writeReadyCount));
        checkCount("bytes on dq", count, countWidth'(gotBytes.size()));
        for (int i = 0; i < gotBytes.size(); i++) begin
            checkByte("dq", expectedByte(i), gotBytes[i]);
        end
    endtask

    initial begin
        int cmd;
        rstN = 1'b0;
        start = 1'b0;
        targetWay = '0;
        numOfData = '0;
        writeData = '0;
        writeValid = 1'b0;
        applyReset();
        for (cmd = 0; cmd < numCommands; cmd++) begin
            runCommand();
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
